// ==== verilog.f ====
hw/usb_pkg.sv
hw/hid_pkg.sv
hw/key_report_fsm.sv
hw/report_byte_counter.sv
hw/report_byte_mux.sv
hw/hid_descriptor_rom.sv
hw/usb_keyboard_app.sv
verif/tb_usb_keyboard_app.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --timing --assert
TOP       = tb_usb_keyboard_app
RTL_TOP   = usb_keyboard_app
FILELIST  = verilog.f
OBJ_DIR   = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/tb_usb_keyboard_app.sv ====
`timescale 1ns/1ps

module tb_usb_keyboard_app
    import usb_pkg::*;
    import hid_pkg::*;
();

    localparam int PAIR_TIMEOUT = 200;   // Cycles allowed for one report pair
    localparam int NUM_KEYS     = 3;

    logic                  clk;
    logic                  usb_rstn;
    logic                  key_valid;
    key_event_t            key_event;
    logic                  key_ready;
    logic                  ep81_valid;
    logic [7:0]            ep81_data;
    logic                  ep81_ready;
    setup_u                ep00_setup;
    logic [RESP_IDX_W-1:0] ep00_resp_idx;
    logic [7:0]            ep00_resp;

    integer seed = 64058;

    usb_keyboard_app usb_keyboard_app_inst (
        .clk           (clk),
        .usb_rstn      (usb_rstn),
        .key_valid     (key_valid),
        .key_event     (key_event),
        .key_ready     (key_ready),
        .ep81_valid    (ep81_valid),
        .ep81_data     (ep81_data),
        .ep81_ready    (ep81_ready),
        .ep00_setup    (ep00_setup),
        .ep00_resp_idx (ep00_resp_idx),
        .ep00_resp     (ep00_resp)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;   // 8 ns period

    // --------------------
    // Failure reporting
    // --------------------

    task automatic fail_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        $display("TESTBENCH FAILED");
        $display("error: time %0t %s got 8'h%h expected 8'h%h", $time, name, got, exp);
        $fatal(1, "%s mismatch", name);
    endtask

    task automatic fail_bit(input string name, input logic got, input logic exp);
        $display("TESTBENCH FAILED");
        $display("error: time %0t %s got %b expected %b", $time, name, got, exp);
        $fatal(1, "%s mismatch", name);
    endtask

    task automatic fail_msg(input string what);
        $display("TESTBENCH FAILED");
        $display("%s", what);
        $fatal(1, "%s", what);
    endtask

    // --------------------
    // Reference model
    // --------------------

    // Press report is modifier, reserved, six key slots; release is all zero
    function automatic logic [7:0] expected_report_byte(input key_event_t ev, input int n);
        logic [7:0] b;
        b = 8'h00;
        if (n == 0) begin
            b = ev.modifier;
        end else if (n == 2) begin
            b = ev.keycode;   // First key slot
        end
        return b;
    endfunction

    // Table byte 0 sits in the top bits
    function automatic logic [7:0] desc_table_byte(input int i);
        return HID_REPORT_DESC[(HID_DESC_LEN - 1 - i) * 8 +: 8];
    endfunction

    // --------------------
    // Stimulus tasks
    // --------------------

    // Called on a falling edge in idle; returns on the edge after the 16th byte
    task automatic run_pair(input key_event_t ev);
        int          sent;
        int          cycles;
        logic        stalled;
        logic [7:0]  held;
        logic [31:0] rnd;
        sent    = 0;
        cycles  = 0;
        stalled = 1'b0;
        held    = 8'h00;
        assert (key_ready === 1'b1) else fail_bit("key_ready", key_ready, 1'b1);
        key_valid = 1'b1;
        key_event = ev;
        @(negedge clk);   // Handshake on the rising edge in between
        assert (ep81_valid === 1'b1) else fail_bit("ep81_valid", ep81_valid, 1'b1);
        key_event = ~ev;   // Junk while busy, valid stays high
        while (sent < 16) begin
            assert (ep81_valid === 1'b1) else fail_bit("ep81_valid", ep81_valid, 1'b1);
            assert (key_ready === 1'b0) else fail_bit("key_ready", key_ready, 1'b0);
            if (stalled) begin
                assert (ep81_data === held) else fail_byte("ep81_data", ep81_data, held);
            end
            rnd        = $random(seed);
            ep81_ready = rnd[0];   // Random back-pressure
            if (ep81_ready) begin
                assert (ep81_data === expected_report_byte(ev, sent))
                    else fail_byte("ep81_data", ep81_data, expected_report_byte(ev, sent));
                sent = sent + 1;
            end
            stalled = ~ep81_ready;
            held    = ep81_data;
            cycles  = cycles + 1;
            if (cycles > PAIR_TIMEOUT) begin
                fail_msg("timeout waiting for the 16 report bytes on endpoint 81");
            end
            @(negedge clk);
        end
        // Pair over, stream drops and the key port opens in the same cycle
        assert (ep81_valid === 1'b0) else fail_bit("ep81_valid", ep81_valid, 1'b0);
        assert (key_ready === 1'b1) else fail_bit("key_ready", key_ready, 1'b1);
    endtask

    // Response shows up one cycle after the index
    task automatic check_desc(input int idx, input logic [7:0] exp);
        ep00_resp_idx = RESP_IDX_W'(idx);
        @(negedge clk);
        assert (ep00_resp === exp) else fail_byte("ep00_resp", ep00_resp, exp);
    endtask

    // --------------------
    // Main sequence
    // --------------------

    initial begin
        key_event_t  ev;
        setup_u      get_desc;
        setup_u      other_req;
        logic [31:0] rnd;
        get_desc                     = '0;
        get_desc.fields.request_type = 8'h81;
        get_desc.fields.request      = 8'h06;
        get_desc.fields.value        = 16'h2200;   // Report descriptor type
        get_desc.fields.length       = 16'd63;
        usb_rstn      = 1'b0;
        key_valid     = 1'b0;
        key_event     = '0;
        ep81_ready    = 1'b0;
        ep00_setup    = get_desc;   // GET_DESCRIPTOR at index 0 right from the start
        ep00_resp_idx = '0;
        repeat (5) @(negedge clk);
        usb_rstn = 1'b1;

        // Reset values, before the first rising edge out of reset
        assert (ep81_valid === 1'b0) else fail_bit("ep81_valid", ep81_valid, 1'b0);
        assert (key_ready === 1'b1) else fail_bit("key_ready", key_ready, 1'b1);
        assert (ep00_resp === 8'h00) else fail_byte("ep00_resp", ep00_resp, 8'h00);
        @(negedge clk);

        // Back to back pairs, key_valid never drops in between
        for (int k = 0; k < NUM_KEYS; k++) begin
            rnd = $random(seed);
            ev  = rnd[15:0];
            run_pair(ev);
        end
        key_valid = 1'b0;
        repeat (4) begin
            @(negedge clk);
            assert (ep81_valid === 1'b0) else fail_bit("ep81_valid", ep81_valid, 1'b0);
        end

        ep00_setup = get_desc;
        for (int i = 0; i < HID_DESC_LEN; i++) begin
            check_desc(i, desc_table_byte(i));
        end
        check_desc(63, 8'h00);    // Just past the table
        check_desc(100, 8'h00);

        // SET_REPORT reads as zero
        other_req                = get_desc;
        other_req.fields.request = 8'h09;
        ep00_setup               = other_req;
        for (int i = 0; i <= HID_DESC_LEN; i++) begin
            check_desc(i, 8'h00);
        end

        // Device recipient, written through the raw byte view
        other_req        = get_desc;
        other_req.raw[0] = 8'h80;
        ep00_setup       = other_req;
        for (int i = 0; i <= HID_DESC_LEN; i++) begin
            check_desc(i, 8'h00);
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== hw/usb_keyboard_app.sv ====
`timescale 1ns/1ps

module usb_keyboard_app
    import usb_pkg::*;
    import hid_pkg::*;
(
    input  logic                  clk,
    input  logic                  usb_rstn,
    // Key events from the host side
    input  logic                  key_valid,
    input  key_event_t            key_event,
    output logic                  key_ready,
    // Interrupt IN endpoint 81
    output logic                  ep81_valid,
    output logic [7:0]            ep81_data,
    input  logic                  ep81_ready,
    // Control endpoint 00
    input  setup_u                ep00_setup,
    input  logic [RESP_IDX_W-1:0] ep00_resp_idx,
    output logic [7:0]            ep00_resp
);

    report_phase_t phase;
    logic          advance;     // ep81 byte moved
    logic          load;        // Key accepted
    logic [2:0]    byte_idx;
    logic          last_byte;

    // --------------------
    // Endpoint 81 path
    // --------------------

    key_report_fsm key_report_fsm_inst (
        .clk        (clk),
        .usb_rstn   (usb_rstn),
        .key_valid  (key_valid),
        .key_ready  (key_ready),
        .ep81_ready (ep81_ready),
        .last_byte  (last_byte),
        .ep81_valid (ep81_valid),
        .advance    (advance),
        .load       (load),
        .phase      (phase)
    );

    report_byte_counter report_byte_counter_inst (
        .clk       (clk),
        .usb_rstn  (usb_rstn),
        .advance   (advance),
        .byte_idx  (byte_idx),
        .last_byte (last_byte)
    );

    report_byte_mux report_byte_mux_inst (
        .clk       (clk),
        .usb_rstn  (usb_rstn),
        .load      (load),
        .key_event (key_event),
        .phase     (phase),
        .byte_idx  (byte_idx),
        .ep81_data (ep81_data)
    );

    // --------------------
    // Endpoint 00 path
    // --------------------

    hid_descriptor_rom hid_descriptor_rom_inst (
        .clk           (clk),
        .usb_rstn      (usb_rstn),
        .ep00_setup    (ep00_setup),
        .ep00_resp_idx (ep00_resp_idx),
        .ep00_resp     (ep00_resp)
    );

endmodule

// ==== hw/hid_descriptor_rom.sv ====
`timescale 1ns/1ps

module hid_descriptor_rom
    import usb_pkg::*;
    import hid_pkg::*;
(
    input  logic                  clk,
    input  logic                  usb_rstn,
    input  setup_u                ep00_setup,
    input  logic [RESP_IDX_W-1:0] ep00_resp_idx,
    output logic [7:0]            ep00_resp
);

    logic       desc_req;       // Setup asks for a descriptor
    logic       idx_in_range;   // Index inside the table
    logic [5:0] desc_addr;      // Byte offset from the top of the table
    logic [7:0] desc_byte;

    // --------------------
    // Request decode
    // --------------------

    assign desc_req = (ep00_setup.fields.request_type == REQ_TYPE_STD_IF_IN) &&
                      (ep00_setup.fields.request == REQ_GET_DESCRIPTOR);

    assign idx_in_range = (ep00_resp_idx < RESP_IDX_W'(HID_DESC_LEN));

    // Byte 0 sits in the top bits of the table
    assign desc_addr = idx_in_range ? (6'(HID_DESC_LEN - 1) - ep00_resp_idx[5:0]) : 6'd0;
    assign desc_byte = HID_REPORT_DESC[desc_addr*8 +: 8];

    // One cycle behind the index
    always_ff @(posedge clk or negedge usb_rstn) begin
        if (!usb_rstn) begin
            ep00_resp <= 8'h00;
        end else if (desc_req && idx_in_range) begin
            ep00_resp <= desc_byte;
        end else begin
            ep00_resp <= 8'h00;   // Other requests read as zero
        end
    end

endmodule

// ==== hw/report_byte_mux.sv ====
`timescale 1ns/1ps

module report_byte_mux
    import hid_pkg::*;
(
    input  logic          clk,
    input  logic          usb_rstn,
    input  logic          load,
    input  key_event_t    key_event,
    input  report_phase_t phase,
    input  logic [2:0]    byte_idx,
    output logic [7:0]    ep81_data
);

    key_event_t key_q;   // Event held for the whole pair

    // --------------------
    // Event capture
    // --------------------

    always_ff @(posedge clk or negedge usb_rstn) begin
        if (!usb_rstn) begin
            key_q <= '0;
        end else if (load) begin
            key_q <= key_event;   // Only on the key handshake
        end
    end

    // --------------------
    // Byte select
    // --------------------

    // Inputs only change on a transfer so data holds while stalled
    always_comb begin
        ep81_data = 8'h00;   // Release report and idle
        if (phase == PH_PRESS) begin
            case (byte_idx)
                3'd0:    ep81_data = key_q.modifier;   // Modifier byte
                3'd2:    ep81_data = key_q.keycode;    // First key slot
                default: ep81_data = 8'h00;            // Reserved and empty slots
            endcase
        end
    end

endmodule

// ==== hw/report_byte_counter.sv ====
`timescale 1ns/1ps

module report_byte_counter
    import hid_pkg::*;
(
    input  logic       clk,
    input  logic       usb_rstn,
    input  logic       advance,
    output logic [2:0] byte_idx,
    output logic       last_byte
);

    localparam logic [2:0] LAST_IDX = 3'(REPORT_LEN - 1);

    // End of the current report
    assign last_byte = (byte_idx == LAST_IDX);

    // --------------------
    // Byte index
    // --------------------

    // Wraps 7 -> 0 so the release report restarts at byte 0
    always_ff @(posedge clk or negedge usb_rstn) begin
        if (!usb_rstn) begin
            byte_idx <= 3'd0;
        end else if (advance) begin
            if (last_byte) begin
                byte_idx <= 3'd0;
            end else begin
                byte_idx <= byte_idx + 3'd1;
            end
        end
    end

endmodule

// ==== hw/key_report_fsm.sv ====
`timescale 1ns/1ps

module key_report_fsm
    import hid_pkg::*;
(
    input  logic          clk,
    input  logic          usb_rstn,
    input  logic          key_valid,
    output logic          key_ready,
    input  logic          ep81_ready,
    input  logic          last_byte,
    output logic          ep81_valid,
    output logic          advance,
    output logic          load,
    output report_phase_t phase
);

    report_phase_t phase_nxt;
    logic          report_end;   // Final byte of a report just moved

    // --------------------
    // Handshakes
    // --------------------

    assign key_ready  = (phase == PH_IDLE);   // Only take keys between pairs
    assign ep81_valid = (phase != PH_IDLE);   // Stream runs through both reports
    assign load       = key_valid & key_ready;
    assign advance    = ep81_valid & ep81_ready;   // One byte transferred
    assign report_end = advance & last_byte;

    // --------------------
    // Phase sequencing
    // --------------------

    always_comb begin
        phase_nxt = phase;
        case (phase)
            PH_IDLE: begin
                if (load) begin
                    phase_nxt = PH_PRESS;   // Valid rises next cycle
                end
            end
            PH_PRESS: begin
                if (report_end) begin
                    phase_nxt = PH_RELEASE;   // No bubble between reports
                end
            end
            PH_RELEASE: begin
                if (report_end) begin
                    phase_nxt = PH_IDLE;   // Pair done, ready again
                end
            end
            default: begin
                phase_nxt = PH_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge usb_rstn) begin
        if (!usb_rstn) begin
            phase <= PH_IDLE;
        end else begin
            phase <= phase_nxt;
        end
    end

endmodule

// ==== hw/hid_pkg.sv ====
package hid_pkg;

    // --------------------
    // Key event and report
    // --------------------

    typedef struct packed {
        logic [7:0] modifier;  // Ctrl/Shift/Alt/GUI bits, 15:8
        logic [7:0] keycode;   // HID usage code, 7:0
    } key_event_t;

    // One boot report fills exactly one ep81 packet
    localparam int REPORT_LEN = usb_pkg::EP81_MAX_PKT;

    localparam int RESP_IDX_W = 9;   // ep00 response index width

    // Which report of the pair is on the wire
    typedef enum logic [1:0] {
        PH_IDLE    = 2'd0,
        PH_PRESS   = 2'd1,
        PH_RELEASE = 2'd2
    } report_phase_t;

    // --------------------
    // Report descriptor
    // --------------------

    localparam int HID_DESC_LEN = 63;

    // Boot keyboard layout, byte 0 in the top bits
    localparam logic [HID_DESC_LEN*8-1:0] HID_REPORT_DESC = {
        48'h05_01_09_06_a1_01,                           // Generic desktop keyboard
        48'h05_07_19_e0_29_e7,                           // Modifier usages E0..E7
        80'h15_00_25_01_75_01_95_08_81_02,               // 8 modifier bits
        48'h95_01_75_08_81_03,                           // Reserved byte
        96'h95_05_75_01_05_08_19_01_29_05_91_02,         // 5 LED outputs
        48'h95_01_75_03_91_03,                           // LED pad to a byte
        128'h95_06_75_08_15_00_25_ff_05_07_19_00_29_65_81_00,  // 6 key array
        8'hc0                                            // End collection
    };

endpackage

// ==== hw/usb_pkg.sv ====
package usb_pkg;

    // --------------------
    // Setup packet layout
    // --------------------

    // Core packs wire byte 0 into bits 7:0
    // So members are listed last byte first to land each on its wire slot
    typedef struct packed {
        logic [15:0] length;        // wLength, bytes 7:6
        logic [15:0] index;         // wIndex, bytes 5:4
        logic [15:0] value;         // wValue, bytes 3:2
        logic [7:0]  request;       // bRequest, byte 1
        logic [7:0]  request_type;  // bmRequestType, byte 0
    } setup_fields_t;

    // Same 64 bits seen two ways
    typedef union packed {
        setup_fields_t   fields;    // Named request fields
        logic [7:0][7:0] raw;       // raw[n] is wire byte n
    } setup_u;

    // --------------------
    // Request constants
    // --------------------

    // Device-to-host, standard, interface recipient
    localparam logic [7:0] REQ_TYPE_STD_IF_IN = 8'h81;

    localparam logic [7:0] REQ_GET_DESCRIPTOR = 8'h06;

    // Interrupt IN endpoint 81 packet size in bytes
    localparam int EP81_MAX_PKT = 8;

endpackage
